//--- hw/wfd_pkg.sv
// master board shared definitions
`default_nettype none

package wfd_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////
    localparam int n_chan      = 5;   // channel FPGAs on the board
    localparam int trig_num_w  = 24;  // trigger number width
    localparam int board_id_w  = 3;   // board id from the strap pins
    localparam int chan_data_w = 32;  // channel stream word
    localparam int daq_data_w  = 64;  // DAQ link word
    localparam int fifo_depth  = 4;   // trigger entries in flight

    localparam int fifo_ptr_w  = $clog2(fifo_depth);  // fifo read/write pointer
    localparam int chan_idx_w  = $clog2(n_chan);      // channel index in payload words
    localparam int word_cnt_w  = 16;                  // payload count in the trailer

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////

    // one bit per channel: enables, go, done, arm
    typedef logic [n_chan-1:0] chan_mask_t;

    // what the trigger manager hands to the builder
    typedef struct packed {
        logic [trig_num_w-1:0] trig_num;   // accepted trigger count, starts at 1
        chan_mask_t            chan_mask;  // channels enabled at acceptance
    } trig_entry_t;

    // one channel's readout stream, valid/last style
    typedef struct packed {
        logic                   valid;
        logic                   last;   // final word of this fill
        logic [chan_data_w-1:0] data;
    } chan_stream_t;

    // word toward the AMC13 DAQ link, valid travels on its own
    typedef struct packed {
        logic                  header;   // first word of an event
        logic                  trailer;  // last word of an event
        logic [daq_data_w-1:0] data;
    } daq_word_t;

endpackage

`default_nettype wire

//--- hw/trigger_manager.sv
// trigger manager
`timescale 1ns/1ps
`default_nettype none

module trigger_manager (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ext_trig,   // front panel trigger, async
    input  wfd_pkg::chan_mask_t  chan_en,
    input  wfd_pkg::chan_mask_t  acq_dones,  // levels from the channels
    output wfd_pkg::chan_mask_t  acq_trigs,  // one-cycle go pulses
    output wfd_pkg::chan_mask_t  trig_arm,
    output logic                 push,
    output wfd_pkg::trig_entry_t entry,
    input  logic                 full
);

    typedef enum logic [1:0] {
        st_idle,  // armed once trig_arm has caught up with chan_en
        st_acq,   // channels filling, collecting dones
        st_push   // waiting for room in the trigger fifo
    } state_t;

    state_t state;

    logic [1:0]                     trig_sync;  // 2-flop synchronizer
    logic                           trig_last;
    logic                           trig_rise;  // registered rising edge
    logic                           armed;
    wfd_pkg::chan_mask_t            mask_q;     // channels of the current fill
    wfd_pkg::chan_mask_t            done_q;     // sticky dones
    wfd_pkg::chan_mask_t            done_next;
    logic [wfd_pkg::trig_num_w-1:0] trig_num;

    //////////////////////////////////////////////////
    // front panel trigger into the 125 MHz domain
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            trig_sync <= '0;
            trig_last <= 1'b0;
            trig_rise <= 1'b0;
        end else begin
            trig_sync <= {trig_sync[0], ext_trig};
            trig_last <= trig_sync[1];
            trig_rise <= trig_sync[1] & ~trig_last;  // one pulse per edge
        end
    end

    assign armed = (state == st_idle) && (trig_arm == chan_en);

    // the channels still show the previous fill's done during the go cycle,
    // they drop it one cycle after go, so that cycle is skipped
    always_comb begin
        done_next = done_q;
        if (acq_trigs == '0) begin
            done_next = done_q | (acq_dones & mask_q);
        end
    end

    //////////////////////////////////////////////////
    // arm / go / done sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            trig_arm  <= '0;
            acq_trigs <= '0;
            mask_q    <= '0;
            done_q    <= '0;
            trig_num  <= '0;
        end else begin
            acq_trigs <= '0;  // go is a single cycle
            case (state)
                st_idle: begin
                    trig_arm <= chan_en;  // follow the enables while idle
                    if (armed && trig_rise) begin
                        trig_arm  <= '0;         // channels stop their ring buffers
                        acq_trigs <= chan_en;
                        mask_q    <= chan_en;
                        done_q    <= '0;
                        trig_num  <= trig_num + 1'b1;  // first fill is number 1
                        state     <= st_acq;
                    end
                end
                st_acq: begin
                    done_q <= done_next;
                    if ((done_next & mask_q) == mask_q) begin
                        state <= st_push;  // every enabled channel reported
                    end
                end
                st_push: begin
                    // full fifo keeps us here, unarmed, and holds off triggers
                    if (!full) begin
                        trig_arm <= chan_en;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign push           = (state == st_push);
    assign entry.trig_num  = trig_num;
    assign entry.chan_mask = mask_q;

    // go only reaches channels that were armed just before the trigger
    a_go_enabled: assert property (@(posedge clk) disable iff (reset)
        (acq_trigs != '0) |-> ((acq_trigs & ~$past(trig_arm)) == '0));

    // no entry is lost or altered while the fifo pushes back
    a_push_held: assert property (@(posedge clk) disable iff (reset)
        (push && full) |=> (push && $stable(entry)));

endmodule

`default_nettype wire

//--- hw/trig_num_fifo.sv
// trigger entry fifo
`timescale 1ns/1ps
`default_nettype none

module trig_num_fifo (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  wfd_pkg::trig_entry_t wr_entry,
    output logic                 full,
    input  logic                 pop,
    output wfd_pkg::trig_entry_t rd_entry,
    output logic                 empty
);

    localparam int ptr_w = wfd_pkg::fifo_ptr_w;

    wfd_pkg::trig_entry_t mem [wfd_pkg::fifo_depth];  // entry storage
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [ptr_w:0]       count;  // one extra bit to tell full from empty
    logic                 wr_en;
    logic                 rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(wfd_pkg::fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(wfd_pkg::fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign full     = (count == (ptr_w + 1)'(wfd_pkg::fifo_depth));
    assign empty    = (count == '0);
    assign rd_entry = mem[rd_ptr];  // head of queue, valid when not empty

    // the builder must look at empty before it pops
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/event_builder.sv
// event builder for the DAQ link
`timescale 1ns/1ps
`default_nettype none

module event_builder (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [wfd_pkg::board_id_w-1:0]    board_id,
    input  logic                              empty,       // trigger fifo
    input  wfd_pkg::trig_entry_t              entry,       // fifo head
    output logic                              pop,
    input  wfd_pkg::chan_stream_t             chan_rx [wfd_pkg::n_chan],
    output wfd_pkg::chan_mask_t               chan_rx_ready,
    output wfd_pkg::daq_word_t                daq_out,
    output logic                              daq_valid,
    input  logic                              daq_ready
);

    localparam int idx_w = wfd_pkg::chan_idx_w;

    typedef enum logic [1:0] {
        st_idle,     // header goes out on the pop
        st_read,     // draining channels in index order
        st_trailer   // all channels done, trailer next
    } state_t;

    state_t state;

    wfd_pkg::trig_entry_t           ent_q;     // entry being built
    wfd_pkg::chan_mask_t            rem_mask;  // channels not yet drained
    wfd_pkg::chan_mask_t            rem_next;
    logic [idx_w-1:0]               cur_chan;  // lowest channel left
    wfd_pkg::chan_stream_t          sel;       // its stream
    logic [wfd_pkg::word_cnt_w-1:0] word_cnt;  // payload words so far
    logic                           out_free;  // output register can take a word
    logic                           rd_fire;   // channel word moves this cycle
    wfd_pkg::daq_word_t             header_word;
    wfd_pkg::daq_word_t             payload_word;
    wfd_pkg::daq_word_t             trailer_word;

    //////////////////////////////////////////////////
    // channel select
    //////////////////////////////////////////////////
    always_comb begin
        cur_chan = '0;
        for (int i = wfd_pkg::n_chan - 1; i >= 0; i--) begin
            if (rem_mask[i]) cur_chan = idx_w'(i);  // lowest set bit wins
        end
    end

    assign sel      = chan_rx[cur_chan];
    assign rem_next = rem_mask & ~(wfd_pkg::chan_mask_t'(1) << cur_chan);
    assign out_free = !daq_valid || daq_ready;  // single register, emptied or leaving
    assign rd_fire  = (state == st_read) && sel.valid && out_free;
    assign pop      = (state == st_idle) && !empty && out_free;

    // ready only toward the channel being read, and only if the word has room
    always_comb begin
        chan_rx_ready = '0;
        if (state == st_read) chan_rx_ready[cur_chan] = out_free;
    end

    //////////////////////////////////////////////////
    // DAQ word formats
    //////////////////////////////////////////////////
    always_comb begin
        header_word.header   = 1'b1;
        header_word.trailer  = 1'b0;
        header_word.data     = {{(wfd_pkg::daq_data_w - 32){1'b0}},
                                board_id, entry.chan_mask, entry.trig_num};
        payload_word.header  = 1'b0;
        payload_word.trailer = 1'b0;
        payload_word.data    = {{(wfd_pkg::daq_data_w - idx_w - wfd_pkg::chan_data_w){1'b0}},
                                cur_chan, sel.data};  // index tags the source channel
        trailer_word.header  = 1'b0;
        trailer_word.trailer = 1'b1;
        trailer_word.data    = {{(wfd_pkg::daq_data_w - wfd_pkg::trig_num_w
                                  - wfd_pkg::word_cnt_w){1'b0}},
                                ent_q.trig_num, word_cnt};
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            daq_valid <= 1'b0;
            rem_mask  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (pop) begin
                        daq_valid <= 1'b1;  // header
                        rem_mask  <= entry.chan_mask;
                        state     <= (entry.chan_mask == '0) ? st_trailer : st_read;
                    end else if (out_free) begin
                        daq_valid <= 1'b0;
                    end
                end
                st_read: begin
                    if (rd_fire) begin
                        daq_valid <= 1'b1;
                        if (sel.last) begin
                            rem_mask <= rem_next;  // channel drained, move on
                            if (rem_next == '0) state <= st_trailer;
                        end
                    end else if (out_free) begin
                        daq_valid <= 1'b0;  // bubble, channel not ready yet
                    end
                end
                st_trailer: begin
                    if (out_free) begin
                        daq_valid <= 1'b1;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // payload side, loaded only when the register is free
    always_ff @(posedge clk) begin
        if (pop) begin
            ent_q    <= entry;
            word_cnt <= '0;
            daq_out  <= header_word;
        end else if (rd_fire) begin
            daq_out  <= payload_word;
            word_cnt <= word_cnt + 1'b1;
        end else if (state == st_trailer && out_free) begin
            daq_out  <= trailer_word;
        end
    end

    // the link may stall, the word on the port must not move under it
    a_daq_hold: assert property (@(posedge clk) disable iff (reset)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_out)));

endmodule

`default_nettype wire

//--- hw/wfd_top.sv
// master board trigger and readout top
`timescale 1ns/1ps
`default_nettype none

module wfd_top (
    input  logic                           clk125,
    input  logic                           reset,
    input  logic                           ext_trig,   // front panel
    input  wfd_pkg::chan_mask_t            chan_en,
    input  logic [wfd_pkg::board_id_w-1:0] board_id,
    input  wfd_pkg::chan_mask_t            acq_dones,
    output wfd_pkg::chan_mask_t            acq_trigs,
    output wfd_pkg::chan_mask_t            trig_arm,
    input  wfd_pkg::chan_stream_t          chan_rx [wfd_pkg::n_chan],
    output wfd_pkg::chan_mask_t            chan_rx_ready,
    output wfd_pkg::daq_word_t             daq_out,    // to the AMC13 link
    output logic                           daq_valid,
    input  logic                           daq_ready
);

    //////////////////////////////////////////////////
    // trigger manager -> fifo -> event builder
    //////////////////////////////////////////////////
    logic                 tm_push;
    wfd_pkg::trig_entry_t tm_entry;
    logic                 fifo_full;
    logic                 fifo_empty;
    wfd_pkg::trig_entry_t fifo_entry;
    logic                 eb_pop;

    trigger_manager tm (
        .clk       (clk125),
        .reset     (reset),
        .ext_trig  (ext_trig),
        .chan_en   (chan_en),
        .acq_dones (acq_dones),
        .acq_trigs (acq_trigs),
        .trig_arm  (trig_arm),
        .push      (tm_push),
        .entry     (tm_entry),
        .full      (fifo_full)
    );

    // fills queue here while earlier ones are read out
    trig_num_fifo trig_fifo (
        .clk      (clk125),
        .reset    (reset),
        .push     (tm_push),
        .wr_entry (tm_entry),
        .full     (fifo_full),
        .pop      (eb_pop),
        .rd_entry (fifo_entry),
        .empty    (fifo_empty)
    );

    event_builder eb (
        .clk           (clk125),
        .reset         (reset),
        .board_id      (board_id),
        .empty         (fifo_empty),
        .entry         (fifo_entry),
        .pop           (eb_pop),
        .chan_rx       (chan_rx),
        .chan_rx_ready (chan_rx_ready),
        .daq_out       (daq_out),
        .daq_valid     (daq_valid),
        .daq_ready     (daq_ready)
    );

endmodule

`default_nettype wire

//--- tests/tb_wfd_top.sv
// master board testbench
`timescale 1ns/1ps
`default_nettype none

module tb_wfd_top;

    localparam int nc = wfd_pkg::n_chan;

    logic                           clk125 = 1'b0;
    logic                           reset;
    logic                           ext_trig;
    wfd_pkg::chan_mask_t            chan_en;
    logic [wfd_pkg::board_id_w-1:0] board_id;
    wfd_pkg::chan_mask_t            acq_dones;
    wfd_pkg::chan_mask_t            acq_trigs;
    wfd_pkg::chan_mask_t            trig_arm;
    wfd_pkg::chan_stream_t          chan_rx [nc];
    wfd_pkg::chan_mask_t            chan_rx_ready;
    wfd_pkg::daq_word_t             daq_out;
    logic                           daq_valid;
    logic                           daq_ready;

    logic [32:0]        chan_q [nc][$];   // {last, data} waiting on each stream
    int                 fill_len [nc];    // words of the latest fill
    logic [31:0]        fill_data [nc][4];
    int                 done_cnt [nc];    // cycles until done rises
    logic [31:0]        rng [nc + 1];     // one state per channel, last one for daq_ready
    wfd_pkg::daq_word_t exp_q [$];        // expected DAQ words in order
    logic [23:0]        exp_num = '0;     // tb's own trigger count
    int                 go_count = 0;
    int                 events_seen = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 ready_mode = 0;   // 0 ready, 1 stalled, 2 random

    always #10 clk125 = ~clk125;  // 50 MHz stand-in for the 125 MHz clock

    wfd_top wfd_top_inst (.*);

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand(input int idx);
        rng[idx] = xorshift32(rng[idx]);
        return rng[idx];
    endfunction

    // header, payload in channel order, trailer
    function automatic void build_expected(input logic [23:0] num,
                                           input wfd_pkg::chan_mask_t mask,
                                           input logic [2:0] bid);
        wfd_pkg::daq_word_t w;
        int                 cnt;
        cnt = 0;
        w = '0;
        w.header = 1'b1;
        w.data[31:0] = {bid, mask, num};
        exp_q.push_back(w);
        for (int c = 0; c < nc; c++) begin
            if (mask[c]) begin
                for (int i = 0; i < fill_len[c]; i++) begin
                    w = '0;
                    w.data[34:0] = {3'(c), fill_data[c][i]};  // index above the word
                    exp_q.push_back(w);
                    cnt++;
                end
            end
        end
        w = '0;
        w.trailer = 1'b1;
        w.data[39:0] = {num, 16'(cnt)};
        exp_q.push_back(w);
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, events %0d", checks, errors, events_seen);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout while waiting for %s at %0t ns", what, $time);
        finish_run();
    endtask

    task automatic end_test(input int n, input string name, input int err0);
        $display("test %0d (%s) finished with %0d errors", n, name, errors - err0);
    endtask

    task automatic step();
        @(posedge clk125);
        #1;  // inputs move just after the edge
    endtask

    task automatic pulse_trigger();
        ext_trig = 1'b1;
        repeat (2) step();
        ext_trig = 1'b0;
        repeat (2) step();
    endtask

    task automatic wait_go(input int target);
        int n;
        for (n = 0; n < 200 && go_count < target; n++) step();
        if (go_count < target) give_up("a go pulse");
    endtask

    task automatic wait_armed();
        int n;
        for (n = 0; n < 500 && trig_arm != chan_en; n++) step();
        if (trig_arm != chan_en) give_up("the manager to re-arm");
    endtask

    task automatic wait_drained();
        int n;
        for (n = 0; n < 3000 && (exp_q.size() != 0 || trig_arm != chan_en); n++) step();
        if (exp_q.size() != 0 || trig_arm != chan_en) give_up("all events to leave");
    endtask

    //////////////////////////////////////////////////
    // channel models
    //////////////////////////////////////////////////
    for (genvar c = 0; c < nc; c++) begin : chan_model
        always begin : model
            logic go;
            logic took;
            @(posedge clk125);
            go   = acq_trigs[c];
            took = chan_rx[c].valid && chan_rx_ready[c];
            #1;
            if (took) void'(chan_q[c].pop_front());
            if (go) begin
                acq_dones[c] = 1'b0;  // done drops with the new fill
                fill_len[c]  = 1 + int'(next_rand(c) % 4);
                for (int i = 0; i < fill_len[c]; i++) begin
                    fill_data[c][i] = next_rand(c);
                    chan_q[c].push_back({i == fill_len[c] - 1, fill_data[c][i]});
                end
                done_cnt[c] = 6 + int'(next_rand(c) % 16);  // long enough for test 4
            end else if (done_cnt[c] > 0) begin
                done_cnt[c]--;
                if (done_cnt[c] == 0) acq_dones[c] = 1'b1;
            end
            chan_rx[c].valid = chan_q[c].size() > 0;
            chan_rx[c].last  = (chan_q[c].size() > 0) ? chan_q[c][0][32] : 1'b0;
            chan_rx[c].data  = (chan_q[c].size() > 0) ? chan_q[c][0][31:0] : '0;
        end
    end

    //////////////////////////////////////////////////
    // go tracker, daq_ready driver, monitor
    //////////////////////////////////////////////////
    always begin : go_tracker
        wfd_pkg::chan_mask_t mask;
        logic [2:0]          bid;
        @(posedge clk125);
        mask = chan_en;
        bid  = board_id;
        if (!reset && acq_trigs != '0) begin
            go_count++;
            exp_num++;
            check(acq_trigs, mask, "go pulse mask");
            #2;  // models record their words at 1 ns
            build_expected(exp_num, mask, bid);
        end
    end

    always begin : ready_driver
        logic [31:0] r;
        @(posedge clk125);
        #1;
        r = next_rand(nc);
        if (ready_mode == 0) daq_ready = 1'b1;
        else if (ready_mode == 1) daq_ready = 1'b0;
        else daq_ready = r[7];
    end

    always begin : daq_monitor
        @(posedge clk125);
        if (!reset) begin
            check(chan_rx_ready & ~chan_en, '0, "ready toward a disabled channel");
            if (daq_valid && daq_ready) begin
                if (daq_out.trailer) events_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected DAQ word %h at %0t ns", daq_out, $time);
                end else begin
                    check(daq_out, exp_q.pop_front(), "DAQ word");
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    initial begin
        int err0;
        int ev0;
        reset     = 1'b1;
        ext_trig  = 1'b0;
        chan_en   = 5'h1f;
        board_id  = 3'd5;
        acq_dones = '0;
        daq_ready = 1'b1;
        for (int i = 0; i <= nc; i++) rng[i] = 32'd23 ^ (i << 16);  // seed 23
        for (int i = 0; i < nc; i++) begin
            chan_rx[i]  = '0;
            fill_len[i] = 0;
            done_cnt[i] = 0;
        end
        repeat (4) @(posedge clk125);
        #1 reset = 1'b0;

        err0 = errors;
        step();
        check(acq_trigs, '0, "go after reset");
        check(daq_valid, 1'b0, "daq_valid after reset");
        step();
        check(trig_arm, chan_en, "trig_arm after reset");
        end_test(1, "reset state", err0);

        err0 = errors;
        ev0  = events_seen;
        pulse_trigger();
        wait_go(1);
        wait_drained();
        check(events_seen - ev0, 1, "events for one trigger");
        end_test(2, "single trigger, all channels", err0);

        err0 = errors;
        ev0  = events_seen;
        chan_en = 5'b10110;  // channels 1, 2 and 4
        wait_armed();
        pulse_trigger();
        wait_go(2);
        wait_drained();
        check(events_seen - ev0, 1, "events for partial mask");
        end_test(3, "partial mask", err0);

        err0 = errors;
        chan_en = 5'h1f;
        wait_armed();
        pulse_trigger();
        wait_go(3);
        pulse_trigger();  // lands while the channels still fill
        wait_drained();
        check(go_count, 3, "go count after ignored trigger");
        pulse_trigger();
        wait_go(4);
        wait_drained();
        end_test(4, "trigger while acquiring", err0);

        err0 = errors;
        ev0  = events_seen;
        ready_mode = 1;  // link stalled
        for (int k = 0; k < 3; k++) begin
            pulse_trigger();
            wait_go(5 + k);
            wait_armed();
        end
        ready_mode = 2;
        wait_drained();
        check(events_seen - ev0, 3, "events after stall");
        end_test(5, "daq back-pressure", err0);

        finish_run();
    end

endmodule

`default_nettype wire

//--- tb.f
hw/wfd_pkg.sv
hw/trigger_manager.sv
hw/trig_num_fifo.sv
hw/event_builder.sv
hw/wfd_top.sv
tests/tb_wfd_top.sv

//--- Bender.yml
package:
  name: wfd_master

sources:
  - files:
      - hw/wfd_pkg.sv
      - hw/trigger_manager.sv
      - hw/trig_num_fifo.sv
      - hw/event_builder.sv
      - hw/wfd_top.sv
  - target: test
    files:
      - tests/tb_wfd_top.sv
